//--- dv/mem_read_path_tb.sv
/*
 * Testbench for the data cache memory read path.
 * Four random requesters and a memory responder drive the DUT from a fixed seed,
 * and a model of grant, slice occupancy and request order checks every cycle.
 * Inputs change on the falling edge and outputs are sampled 1 ns before the rising edge.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module mem_read_path_tb;

    localparam int N_PER      = 100;                       // Requests per requester
    localparam int TIMEOUT_NS = 4 * N_PER * 40 * 8;        // 400 requests at 40 cycles of 8 ns

    logic                  clk_i = 1'b0;
    logic                  reset_i;
    logic [`MEM_N_REQ-1:0] req_valid_i;
    mem_pkg::mem_req_t     req_i [`MEM_N_REQ];
    logic [`MEM_N_REQ-1:0] req_ready_o;
    logic                  mem_req_valid_o;
    mem_pkg::mem_req_src_t mem_req_o;
    logic                  mem_req_ready_i;
    logic                  mem_resp_valid_i;
    mem_pkg::mem_resp_t    mem_resp_i;
    logic                  mem_resp_ready_o;
    logic [`MEM_N_REQ-1:0] resp_valid_o;
    mem_pkg::mem_resp_t    resp_o;
    logic [`MEM_N_REQ-1:0] resp_ready_i;

    integer                seed = 15935;
    mem_pkg::mem_req_t     req_list [`MEM_N_REQ][N_PER]; // What each requester will issue
    int                    sent [`MEM_N_REQ];           // Requests accepted per port
    int                    rcount [`MEM_N_REQ];         // Responses received per port
    logic [`MEM_N_REQ-1:0] accepted;                    // Port transferred at the last edge
    mem_pkg::mem_req_src_t exp_q [$];                   // Accepted but not yet at memory
    mem_pkg::mem_req_src_t mem_q [$];                   // At memory and awaiting a response
    int                    accepted_total = 0;
    int                    mem_sent = 0;
    int                    held = -1;                   // Port whose grant is held, -1 if none
    logic                  stall_prev = 1'b0;
    mem_pkg::mem_req_src_t prev_mem_req;
    logic                  resp_taken = 1'b0;           // Response was consumed at the last edge
    int                    resp_wait = 0;               // Idle cycles before the next response
    mem_pkg::slice_state_e slice_state;                 // Copied from the DUT for the timeout note

    mem_read_path dut (.*);

    always #4 clk_i = ~clk_i; // 8 ns period

    // Uniform value in 0 to n-1 from the seeded generator
    function automatic int pick_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // Data that memory returns for a read of addr
    function automatic logic [`MEM_DATA_WIDTH-1:0] data_for(input logic [`MEM_ADDR_WIDTH-1:0] addr);
        return {~addr, addr ^ 32'h9e37_79b9};
    endfunction

    function automatic logic all_done();
        for (int i = 0; i < `MEM_N_REQ; i++) begin
            if (rcount[i] < N_PER) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_equal(input logic [127:0] got, input logic [127:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, expected);
            stop_with_failure();
        end
    endtask

    // New inputs for the coming cycle, holding any valid that has not transferred yet
    task automatic drive_inputs();
        for (int i = 0; i < `MEM_N_REQ; i++) begin
            if (!req_valid_i[i] || accepted[i]) begin
                if (sent[i] < N_PER && pick_below(3) != 0) begin
                    req_valid_i[i] = 1'b1;
                    req_i[i]       = req_list[i][sent[i]];
                end else begin
                    req_valid_i[i] = 1'b0;
                end
            end
            resp_ready_i[i] = (pick_below(4) != 0);
        end
        accepted        = '0;
        mem_req_ready_i = (pick_below(10) < 7); // About 70 percent
        if (!mem_resp_valid_i || resp_taken) begin
            mem_resp_valid_i = 1'b0;
            if (mem_q.size() > 0 && resp_wait == 0) begin
                mem_resp_valid_i = 1'b1; // Source and tag are echoed from the request
                mem_resp_i = '{src: mem_q[0].src, tag: mem_q[0].tag,
                               data: data_for(mem_q[0].addr), error: mem_q[0].addr[0]};
            end else if (mem_q.size() > 0) begin
                resp_wait--;
            end
        end
        resp_taken = 1'b0;
    endtask

    // Checks the values that the coming rising edge will act on and updates the model
    task automatic check_cycle();
        int                    count;
        int                    exp_gnt;
        int                    p;
        int                    idx;
        logic                  exp_arb_ready;
        logic [`MEM_N_REQ-1:0] exp_vec;
        mem_pkg::mem_req_src_t stamped;
        count         = accepted_total - mem_sent; // Entries now inside the slice
        exp_arb_ready = (count < 2);
        exp_gnt       = held;
        for (int i = `MEM_N_REQ - 1; i >= 0; i--) begin
            if (held < 0 && req_valid_i[i]) exp_gnt = i; // Lowest valid index wins
        end
        exp_vec = '0;
        if (exp_gnt >= 0 && exp_arb_ready) exp_vec[exp_gnt] = 1'b1;
        check_equal(128'(req_ready_o), 128'(exp_vec), "req_ready_o against expected grant");
        held = exp_arb_ready ? -1 : exp_gnt; // Grant stays until the slice takes it
        check_equal(128'(mem_req_valid_o), 128'(count > 0), "mem_req_valid_o against occupancy");
        if (stall_prev) begin
            check_equal(128'(mem_req_o), 128'(prev_mem_req), "mem_req_o changed under stall");
        end
        stall_prev   = mem_req_valid_o && !mem_req_ready_i;
        prev_mem_req = mem_req_o;
        if (mem_req_valid_o && mem_req_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("memory request at %0t ns with no accepted request left", $time);
                stop_with_failure();
            end
            check_equal(128'(mem_req_o), 128'(exp_q[0]), "memory request against accept order");
            void'(exp_q.pop_front());
            mem_q.push_back(mem_req_o);
            mem_sent++;
        end
        for (int i = 0; i < `MEM_N_REQ; i++) begin
            if (req_valid_i[i] && req_ready_o[i]) begin
                stamped = '{src: `MEM_SRC_WIDTH'(i), addr: req_i[i].addr, tag: req_i[i].tag};
                exp_q.push_back(stamped);
                accepted[i] = 1'b1;
                sent[i]++;
                accepted_total++;
            end
        end
        exp_vec = '0;
        if (mem_resp_valid_i) begin
            p          = int'(mem_resp_i.src);
            exp_vec[p] = 1'b1;
            check_equal(128'(resp_valid_o), 128'(exp_vec), "resp_valid_o against source");
            check_equal(128'(resp_o), 128'(mem_resp_i), "resp_o against memory response");
            check_equal(128'(mem_resp_ready_o), 128'(resp_ready_i[p]), "mem_resp_ready_o");
            if (mem_resp_ready_o) begin
                idx = rcount[p]; // Responses return in issue order per requester
                if (idx >= N_PER) begin
                    $display("requester %0d got more responses than it issued", p);
                    stop_with_failure();
                end
                check_equal(128'(resp_o.tag), 128'(req_list[p][idx].tag), "response tag");
                check_equal(128'(resp_o.data), 128'(data_for(req_list[p][idx].addr)),
                            "response data");
                check_equal(128'(resp_o.error), 128'(req_list[p][idx].addr[0]), "error bit");
                rcount[p]++;
                resp_taken = 1'b1;
                void'(mem_q.pop_front());
                resp_wait = pick_below(4);
            end
        end else begin
            check_equal(128'(resp_valid_o), 128'(exp_vec), "resp_valid_o with no response");
        end
    endtask

    initial begin
        reset_i          = 1'b1;
        req_valid_i      = '0;
        mem_req_ready_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_i       = '0;
        resp_ready_i     = '0;
        accepted         = '0;
        for (int i = 0; i < `MEM_N_REQ; i++) begin
            req_i[i]  = '0;
            sent[i]   = 0;
            rcount[i] = 0;
            for (int k = 0; k < N_PER; k++) begin
                req_list[i][k].addr = $random(seed);
                req_list[i][k].tag  = `MEM_TAG_WIDTH'(pick_below(16));
            end
        end
        repeat (8) @(negedge clk_i);
        reset_i = 1'b0;
        while (!all_done()) begin
            drive_inputs();
            #3;
            check_cycle();
            @(negedge clk_i);
        end
        // Idle cycles after the last response, any further memory request is an extra one
        repeat (8) begin
            drive_inputs();
            #3;
            check_cycle();
            @(negedge clk_i);
        end
        $display("sim passed");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        slice_state = dut.u_slice.state_q;
        $display("timeout after %0t ns with %0d of %0d requests sent to memory, slice %s",
                 $time, mem_sent, 4 * N_PER, slice_state.name());
        stop_with_failure();
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/mem_pkg.sv
source/mem_fxarb.sv
source/mem_req_read_arbiter.sv
source/mem_req_slice.sv
source/mem_resp_read_demux.sv
source/mem_read_path.sv
dv/mem_read_path_tb.sv

//--- run.sh
#!/bin/sh
# Compiles the read path testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the testbench stops with $fatal.

cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module mem_read_path_tb -o mem_read_path_sim &&
./obj_dir/mem_read_path_sim ||
{
    echo "build or simulation returned an error"
    exit 1
}

//--- source/mem_fxarb.sv
/*
 * Fixed-priority arbiter with grant hold.
 * The lowest-index active request wins, and the grant stays frozen
 * while the downstream ready is low so the payload cannot switch mid-transfer.
 */
`timescale 1ns/1ns
`default_nettype none

module mem_fxarb #(
    parameter int unsigned N = 4 // Number of requesters, 1 or more
) (
    input  logic         clk_i,
    input  logic         reset_i,
    input  logic [N-1:0] req_i,   // One request bit per requester
    input  logic         ready_i, // Downstream accepts in this cycle
    output logic [N-1:0] gnt_o    // One-hot grant, or zero when nothing requests
);

    logic [N-1:0] gnt_lowest; // Lowest-index set bit of req_i
    logic [N-1:0] gnt_held_q; // Grant kept from an earlier cycle that was not accepted
    logic         held;

    // Two's complement trick isolates the lowest set bit
    assign gnt_lowest = req_i & (~req_i + 1'b1);

    assign held = |gnt_held_q;

    // A held grant overrides fresh arbitration
    assign gnt_o = held ? gnt_held_q : gnt_lowest;

    // Hold register
    // When ready is high the granted requester transfers in this cycle, so the next cycle
    // arbitrates afresh
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            gnt_held_q <= '0;
        end else if (ready_i) begin
            gnt_held_q <= '0; // Transfer done or nothing granted
        end else begin
            gnt_held_q <= gnt_o; // Freeze the current winner, stays zero if idle
        end
    end

endmodule

`default_nettype wire

//--- source/mem_params.svh
/*
 * Widths and counts shared by the data cache memory read path.
 * Include this header wherever one of these macros is needed.
 * The package takes its struct widths from here as well.
 */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Number of internal read requesters (miss handler, prefetcher, uncached unit and one spare)
`define MEM_N_REQ 4

// Width of the source index stamped by the arbiter, ceiling of log2 of MEM_N_REQ
`define MEM_SRC_WIDTH 2

`define MEM_ADDR_WIDTH 32 // Byte address toward memory
`define MEM_TAG_WIDTH 4   // Requester-local transaction tag

// Read response data width
`define MEM_DATA_WIDTH 64

`endif

//--- source/mem_pkg.sv
/*
 * Types for the data cache memory read path.
 * Holds the request and response structs and the skid slice state enum.
 * Modules refer to these types by scoped name.
 */
`default_nettype none

`include "mem_params.svh"

package mem_pkg;

    // Request as issued by one requester, before the arbiter stamps it
    typedef struct packed {
        logic [`MEM_ADDR_WIDTH-1:0] addr; // Read address
        logic [`MEM_TAG_WIDTH-1:0]  tag;  // Requester's own transaction id
    } mem_req_t;

    // Request as seen at the memory port
    typedef struct packed {
        logic [`MEM_SRC_WIDTH-1:0]  src;  // Index of the requester that won arbitration
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [`MEM_TAG_WIDTH-1:0]  tag;
    } mem_req_src_t;

    // Read response coming back from memory
    typedef struct packed {
        logic [`MEM_SRC_WIDTH-1:0]  src;   // Copied from the request and used for routing
        logic [`MEM_TAG_WIDTH-1:0]  tag;   // Copied from the request
        logic [`MEM_DATA_WIDTH-1:0] data;
        logic                       error; // Passed through to the requester untouched
    } mem_resp_t;

    // Occupancy of the two-entry skid slice
    typedef enum logic [1:0] {
        SLICE_EMPTY, // Nothing held and output invalid
        SLICE_ONE,   // Main register holds the output entry
        SLICE_TWO    // Spare register also holds an entry so input ready is low
    } slice_state_e;

endpackage

`default_nettype wire

//--- source/mem_read_path.sv
/*
 * Memory read path of the data cache.
 * Requests go through the fixed-priority arbiter and the registered slice
 * to the memory port, and responses come back through the source demux.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module mem_read_path (
    input  logic                  clk_i,
    input  logic                  reset_i,

    // Requester request channels
    input  logic [`MEM_N_REQ-1:0] req_valid_i,
    input  mem_pkg::mem_req_t     req_i [`MEM_N_REQ],
    output logic [`MEM_N_REQ-1:0] req_ready_o,

    // Memory request port
    output logic                  mem_req_valid_o,
    output mem_pkg::mem_req_src_t mem_req_o,
    input  logic                  mem_req_ready_i,

    // Memory response port
    input  logic                  mem_resp_valid_i,
    input  mem_pkg::mem_resp_t    mem_resp_i,
    output logic                  mem_resp_ready_o,

    // Requester response channels, payload shared
    output logic [`MEM_N_REQ-1:0] resp_valid_o,
    output mem_pkg::mem_resp_t    resp_o,
    input  logic [`MEM_N_REQ-1:0] resp_ready_i
);

    logic                  arb_valid; // Arbiter to slice handshake
    logic                  arb_ready;
    mem_pkg::mem_req_src_t arb_req;

    mem_req_read_arbiter #(
        .N           (`MEM_N_REQ)
    ) u_arbiter (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .arb_ready_i (arb_ready),
        .arb_valid_o (arb_valid),
        .arb_req_o   (arb_req)
    );

    // Registered stage between the arbiter and memory
    mem_req_slice u_slice (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_valid_i  (arb_valid),
        .in_req_i    (arb_req),
        .in_ready_o  (arb_ready),
        .out_valid_o (mem_req_valid_o),
        .out_req_o   (mem_req_o),
        .out_ready_i (mem_req_ready_i)
    );

    mem_resp_read_demux #(
        .N                (`MEM_N_REQ)
    ) u_resp_demux (
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_i       (mem_resp_i),
        .mem_resp_ready_o (mem_resp_ready_o),
        .resp_valid_o     (resp_valid_o),
        .resp_o           (resp_o),
        .resp_ready_i     (resp_ready_i)
    );

endmodule

`default_nettype wire

//--- source/mem_req_read_arbiter.sv
/*
 * Read request channel arbiter.
 * Picks one requester with the fixed-priority arbiter, forwards its request
 * with the winning index stamped into the source field, and returns the
 * downstream ready to the granted port only.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module mem_req_read_arbiter #(
    parameter int unsigned N = 4 // Number of read requesters
) (
    input  logic                   clk_i,
    input  logic                   reset_i,

    // Requester side
    input  logic [N-1:0]           req_valid_i,
    input  mem_pkg::mem_req_t      req_i [N],
    output logic [N-1:0]           req_ready_o,

    // Toward the request slice
    input  logic                   arb_ready_i,
    output logic                   arb_valid_o,
    output mem_pkg::mem_req_src_t  arb_req_o
);

    logic [N-1:0]              gnt;     // One-hot grant from the arbiter
    mem_pkg::mem_req_t         sel_req; // Granted request before stamping
    logic [`MEM_SRC_WIDTH-1:0] sel_src; // Binary index of the granted requester

    mem_fxarb #(
        .N       (N)
    ) u_fxarb (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (req_valid_i),
        .ready_i (arb_ready_i),
        .gnt_o   (gnt)
    );

    // Grant is derived from valid, so any grant bit means a valid request
    assign arb_valid_o = |(gnt & req_valid_i);

    // One-hot AND-OR multiplexer and grant encoder
    // Only one grant bit is set, so OR-ing the masked terms picks exactly one entry
    always_comb begin
        sel_req = '0;
        sel_src = '0;
        for (int i = 0; i < N; i++) begin
            sel_req = sel_req | ({$bits(mem_pkg::mem_req_t){gnt[i]}} & req_i[i]);
            sel_src = sel_src | ({`MEM_SRC_WIDTH{gnt[i]}} & `MEM_SRC_WIDTH'(i));
        end
    end

    // Stamp the source so the response can find its way back
    assign arb_req_o = '{
        src:  sel_src,
        addr: sel_req.addr,
        tag:  sel_req.tag
    };

    // Ready goes back to the winner alone
    always_comb begin
        for (int i = 0; i < N; i++) begin
            req_ready_o[i] = arb_ready_i & gnt[i] & req_valid_i[i];
        end
    end

endmodule

`default_nettype wire

//--- source/mem_req_slice.sv
/*
 * Two-entry skid buffer on the request channel toward memory.
 * All outputs, including the input ready, come straight from registers,
 * which cuts the combinational ready path from memory into the arbiter.
 * A full stream passes with one cycle of latency and no bubbles.
 */
`timescale 1ns/1ns
`default_nettype none

module mem_req_slice (
    input  logic                  clk_i,
    input  logic                  reset_i,

    // Input side, from the arbiter
    input  logic                  in_valid_i,
    input  mem_pkg::mem_req_src_t in_req_i,
    output logic                  in_ready_o,

    // Output side, toward memory
    output logic                  out_valid_o,
    output mem_pkg::mem_req_src_t out_req_o,
    input  logic                  out_ready_i
);

    mem_pkg::slice_state_e state_q;
    mem_pkg::slice_state_e state_d;

    mem_pkg::mem_req_src_t main_q;  // Entry presented on the output
    mem_pkg::mem_req_src_t spare_q; // Second entry caught while the output stalls

    logic in_ready_q;
    logic out_valid_q;

    logic push;       // Input transfer in this cycle
    logic pop;        // Output transfer in this cycle
    logic main_load;  // Main register takes a new entry
    logic main_spare; // That entry comes from the spare register instead of the input
    logic spare_load;

    assign push = in_valid_i & in_ready_q;
    assign pop  = out_valid_q & out_ready_i;

    // Next state and register load controls
    always_comb begin
        state_d    = state_q;
        main_load  = 1'b0;
        main_spare = 1'b0;
        spare_load = 1'b0;
        case (state_q)
            mem_pkg::SLICE_EMPTY: begin
                if (push) begin
                    main_load = 1'b1;
                    state_d   = mem_pkg::SLICE_ONE;
                end
            end
            mem_pkg::SLICE_ONE: begin
                if (push && pop) begin
                    main_load = 1'b1; // Streaming, the new entry replaces the departing one
                end else if (push) begin
                    spare_load = 1'b1; // Output stalled so park the new entry
                    state_d    = mem_pkg::SLICE_TWO;
                end else if (pop) begin
                    state_d = mem_pkg::SLICE_EMPTY;
                end
            end
            mem_pkg::SLICE_TWO: begin
                // Input ready is low here, so only a pop can happen
                if (pop) begin
                    main_load  = 1'b1;
                    main_spare = 1'b1; // Older entry moves up and keeps the order
                    state_d    = mem_pkg::SLICE_ONE;
                end
            end
            default: begin
                state_d = mem_pkg::SLICE_EMPTY;
            end
        endcase
    end

    // Control registers
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= mem_pkg::SLICE_EMPTY;
            in_ready_q  <= 1'b1;
            out_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            in_ready_q  <= (state_d != mem_pkg::SLICE_TWO);   // Room for at least one more
            out_valid_q <= (state_d != mem_pkg::SLICE_EMPTY);
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (main_load) begin
            main_q <= main_spare ? spare_q : in_req_i;
        end
        if (spare_load) begin
            spare_q <= in_req_i;
        end
    end

    assign in_ready_o  = in_ready_q;
    assign out_valid_o = out_valid_q;
    assign out_req_o   = main_q;

endmodule

`default_nettype wire

//--- source/mem_resp_read_demux.sv
/*
 * Read response router.
 * Sends each memory response to the requester named in its source field.
 * The payload is shared by all requesters and only the valids are split.
 */
`timescale 1ns/1ns
`default_nettype none

module mem_resp_read_demux #(
    parameter int unsigned N = 4 // Number of read requesters
) (
    // From memory
    input  logic               mem_resp_valid_i,
    input  mem_pkg::mem_resp_t mem_resp_i,
    output logic               mem_resp_ready_o,

    // Toward the requesters
    output logic [N-1:0]       resp_valid_o,
    output mem_pkg::mem_resp_t resp_o,
    input  logic [N-1:0]       resp_ready_i
);

    logic [N-1:0] src_match; // One-hot decode of the source field

    // A source of N or more matches nothing, so that response stalls with ready low
    always_comb begin
        for (int i = 0; i < N; i++) begin
            src_match[i] = (int'(mem_resp_i.src) == i);
        end
    end

    assign resp_valid_o = {N{mem_resp_valid_i}} & src_match;

    // Memory sees the ready of the addressed requester only
    assign mem_resp_ready_o = |(resp_ready_i & src_match);

    assign resp_o = mem_resp_i; // Error bit and data pass through unchanged

endmodule

`default_nettype wire
